// File: common/axi_bridge_consts.svh
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// bus and line geometry
`define ADDR_W          32
`define WORD_W          32
`define LINE_WORDS      4
`define LINE_W          128     // LINE_WORDS beats of WORD_W

`define ID_W            4

// request queue between arbiter and read engine
`define REQ_FIFO_DEPTH  4

// AXI encodings for the AR channel
`define AXI_SIZE_WORD   3'd2    // 4 bytes per beat
`define AXI_BURST_INCR  2'd1

// source code of a request, doubles as the AXI id
`define SRC_ICACHE      1'b0
`define SRC_UNCACHED    1'b1

`endif

// File: common/axi_bridge_pkg.sv
`include "axi_bridge_consts.svh"

package axi_bridge_pkg;

    // who asked for the read
    typedef enum logic {
        src_icache   = `SRC_ICACHE,
        src_uncached = `SRC_UNCACHED
    } src_t;

    // queued read request
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        src_t               src;
    } rd_req_t;

    // read address channel payload
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`ADDR_W-1:0] addr;
        logic [3:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`WORD_W-1:0] data;
        logic [1:0]         resp;
        logic               last;
    } axi_r_t;

    // word 0 of the line in the low bits
    typedef logic [`LINE_W-1:0] line_t;

endpackage

// File: logic/req_fifo.sv
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module req_fifo #(
    parameter int DEPTH = `REQ_FIFO_DEPTH
) (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    push,
    input  axi_bridge_pkg::rd_req_t din,
    input  logic                    pop,
    output axi_bridge_pkg::rd_req_t dout,
    output logic                    full,
    output logic                    empty
);
    import axi_bridge_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rd_req_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // entries held
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];  // head shows one cycle after its push

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

endmodule

// File: axi_bridge/rd_arbiter.sv
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module rd_arbiter (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    icache_req,
    input  logic [`ADDR_W-1:0]      icache_addr,
    output logic                    icache_rdy,
    input  logic                    uc_req,
    input  logic [`ADDR_W-1:0]      uc_addr,
    output logic                    uc_rdy,
    input  logic                    full,
    output logic                    push,
    output axi_bridge_pkg::rd_req_t req
);
    import axi_bridge_pkg::*;

    // byte offset bits inside one line
    localparam int OFS_W = $clog2(`LINE_W / 8);

    logic last_ic;  // icache won the last grant
    logic ic_take;
    logic uc_take;

    // when both wait the side that did not win last time goes first
    assign icache_rdy = !full && (!uc_req || !last_ic);
    assign uc_rdy     = !full && (!icache_req || last_ic);

    assign ic_take = icache_req && icache_rdy;
    assign uc_take = uc_req && uc_rdy;
    assign push    = ic_take || uc_take;  // written into the queue at this edge

    always_comb begin
        if (ic_take) begin
            // refills always fetch the whole line
            req.addr = {icache_addr[`ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
            req.src  = src_icache;
        end else begin
            req.addr = uc_addr;
            req.src  = src_uncached;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            last_ic <= 1'b0;  // icache first after reset
        end else if (ic_take) begin
            last_ic <= 1'b1;
        end else if (uc_take) begin
            last_ic <= 1'b0;
        end
    end

endmodule

// File: axi_bridge/axi_rd_engine.sv
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_rd_engine (
    input  logic                    aclk,
    input  logic                    arst_n,
    // request queue head
    input  axi_bridge_pkg::rd_req_t head,
    input  logic                    empty,
    output logic                    pop,
    // AR channel
    output axi_bridge_pkg::axi_ar_t ar,
    output logic                    arvalid,
    input  logic                    arready,
    // R channel
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    output logic                    rready,
    // returns
    output logic                    icache_ret_valid,
    output axi_bridge_pkg::line_t   icache_ret_data,
    output logic                    uc_ret_valid,
    output logic [`WORD_W-1:0]      uc_ret_data
);
    import axi_bridge_pkg::*;

    localparam int BEAT_W = $clog2(`LINE_WORDS);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t            state;
    rd_req_t           cur;         // request owning the bus
    logic [BEAT_W-1:0] beat_cnt;
    line_t             line_q;
    logic              beat_ok;

    // one burst at a time, next head taken only from idle
    assign pop     = (state == st_idle) && !empty;
    assign arvalid = (state == st_addr);
    assign rready  = (state == st_data);
    assign beat_ok = rvalid && rready;

    // AR fields come from the latched request so they hold while stalled
    always_comb begin
        ar.id    = {{(`ID_W-1){1'b0}}, cur.src};
        ar.addr  = cur.addr;
        ar.len   = (cur.src == src_icache) ? 4'(`LINE_WORDS - 1) : 4'd0;
        ar.size  = `AXI_SIZE_WORD;
        ar.burst = `AXI_BURST_INCR;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state            <= st_idle;
            beat_cnt         <= '0;
            icache_ret_valid <= 1'b0;
            uc_ret_valid     <= 1'b0;
        end else begin
            // single-cycle return pulses
            icache_ret_valid <= 1'b0;
            uc_ret_valid     <= 1'b0;
            case (state)
                st_idle: begin
                    beat_cnt <= '0;
                    if (pop)
                        state <= st_addr;
                end
                st_addr: begin
                    if (arready)
                        state <= st_data;
                end
                st_data: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state            <= st_idle;
                            icache_ret_valid <= (cur.src == src_icache);
                            uc_ret_valid     <= (cur.src == src_uncached);
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (pop)
            cur <= head;
        // beat k lands in word k of the line
        if (beat_ok)
            line_q[beat_cnt*`WORD_W +: `WORD_W] <= r.data;
    end

    // line_q holds until the next burst starts, after the pulse
    assign icache_ret_data = line_q;
    assign uc_ret_data     = line_q[`WORD_W-1:0];  // single beat is word 0

endmodule

// File: axi_bridge/axi_bridge_top.sv
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_bridge_top (
    input  logic                    aclk,
    input  logic                    arst_n,
    // icache line refill requester
    input  logic                    icache_req,
    input  logic [`ADDR_W-1:0]      icache_addr,
    output logic                    icache_rdy,
    // uncached word requester
    input  logic                    uc_req,
    input  logic [`ADDR_W-1:0]      uc_addr,
    output logic                    uc_rdy,
    // AXI read channels
    output axi_bridge_pkg::axi_ar_t ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    output logic                    rready,
    // returns
    output logic                    icache_ret_valid,
    output axi_bridge_pkg::line_t   icache_ret_data,
    output logic                    uc_ret_valid,
    output logic [`WORD_W-1:0]      uc_ret_data
);
    import axi_bridge_pkg::*;

    logic    fifo_push;
    rd_req_t fifo_din;
    logic    fifo_full;
    logic    fifo_pop;
    rd_req_t fifo_head;
    logic    fifo_empty;

    rd_arbiter arb_i (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .icache_req  (icache_req),
        .icache_addr (icache_addr),
        .icache_rdy  (icache_rdy),
        .uc_req      (uc_req),
        .uc_addr     (uc_addr),
        .uc_rdy      (uc_rdy),
        .full        (fifo_full),
        .push        (fifo_push),
        .req         (fifo_din)
    );

    req_fifo #(
        .DEPTH (`REQ_FIFO_DEPTH)
    ) fifo_i (
        .aclk   (aclk),
        .arst_n (arst_n),
        .push   (fifo_push),
        .din    (fifo_din),
        .pop    (fifo_pop),
        .dout   (fifo_head),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    axi_rd_engine eng_i (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .head             (fifo_head),
        .empty            (fifo_empty),
        .pop              (fifo_pop),
        .ar               (ar),
        .arvalid          (arvalid),
        .arready          (arready),
        .r                (r),
        .rvalid           (rvalid),
        .rready           (rready),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_data  (icache_ret_data),
        .uc_ret_valid     (uc_ret_valid),
        .uc_ret_data      (uc_ret_data)
    );

endmodule

// File: bench/axi_bridge_chk.sv
`timescale 1ns/1ps

module axi_bridge_chk (
    input logic                    aclk,
    input logic                    arst_n,
    input axi_bridge_pkg::axi_ar_t ar,
    input logic                    arvalid,
    input logic                    arready,
    input logic                    icache_ret_valid,
    input logic                    uc_ret_valid
);

    // address phase must hold until the slave takes it
    ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar changed or arvalid dropped before arready");

    ic_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        icache_ret_valid |=> !icache_ret_valid)
        else $error("icache_ret_valid held for more than one cycle");

    uc_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        uc_ret_valid |=> !uc_ret_valid)
        else $error("uc_ret_valid held for more than one cycle");

    // a return can only follow the data phase
    no_ret_in_addr: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid |-> !(icache_ret_valid || uc_ret_valid))
        else $error("return raised during the address phase");

endmodule

bind axi_bridge_top axi_bridge_chk chk_i (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .ar               (ar),
    .arvalid          (arvalid),
    .arready          (arready),
    .icache_ret_valid (icache_ret_valid),
    .uc_ret_valid     (uc_ret_valid)
);

// File: bench/axi_bridge_tb.sv
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_bridge_tb;
    import axi_bridge_pkg::*;

    localparam int NUM_VEC  = 14;
    localparam int WAIT_MAX = 2000;   // cycles per wait loop

    // beats is the burst length expected on the bus
    typedef struct packed {
        src_t               src;
        logic [`ADDR_W-1:0] addr;
        logic [2:0]         beats;
    } vec_t;

    logic               aclk = 1'b0;
    logic               arst_n;
    logic               icache_req;
    logic [`ADDR_W-1:0] icache_addr;
    logic               icache_rdy;
    logic               uc_req;
    logic [`ADDR_W-1:0] uc_addr;
    logic               uc_rdy;
    axi_ar_t            ar;
    logic               arvalid;
    logic               arready = 1'b0;
    axi_r_t             r = '0;
    logic               rvalid = 1'b0;
    logic               rready;
    logic               icache_ret_valid;
    line_t              icache_ret_data;
    logic               uc_ret_valid;
    logic [`WORD_W-1:0] uc_ret_data;

    vec_t        vec_tab [NUM_VEC];
    vec_t        exp_log [$];       // accepted requests in order
    logic [31:0] lfsr = 32'h77b80567;
    logic        stall_on = 1'b0;
    logic        full_seen = 1'b0;
    int          q_cnt = 0;         // requests waiting in the queue
    logic        eng_busy = 1'b0;   // a burst owns the bus
    int          ar_idx = 0;
    int          ret_idx = 0;
    int          beat_idx = 0;
    logic        burst_on = 1'b0;
    axi_ar_t     cur_ar;
    vec_t        cur_vec;
    int          tb_errors = 0;
    int          bus_errors = 0;
    int          ret_errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    axi_bridge_top dut_i (.*);

    always #50 aclk = ~aclk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    function automatic logic take_bit();
        lfsr = next_lfsr(lfsr);
        return lfsr[0];
    endfunction

    // ready three cycles in four while stalls are on
    function automatic logic ready_draw();
        logic b0;
        logic b1;
        if (!stall_on)
            return 1'b1;
        b0 = take_bit();
        b1 = take_bit();
        return !(b0 && b1);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    // refills go out line-aligned, uncached words as given
    function automatic logic [31:0] bus_addr(input vec_t v);
        return (v.src == src_icache) ? {v.addr[31:4], 4'h0} : v.addr;
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    endtask

    // AXI slave, one burst at a time
    always @(posedge aclk) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            burst_on = 1'b0;
        end else if (!burst_on) begin
            if (arvalid && arready) begin
                cur_ar = ar;
                beat_idx = 0;
                burst_on = 1'b1;
                arready <= 1'b0;
                if (ar_idx >= exp_log.size()) begin
                    $display("[ERROR] %0t ns AR seen with no request outstanding", $time);
                    bus_errors++;
                    cur_vec = '0;
                end else begin
                    cur_vec = exp_log[ar_idx];
                    ar_idx++;
                    if (ar.addr != bus_addr(cur_vec)) begin
                        report_value("ar.addr", 128'(ar.addr), 128'(bus_addr(cur_vec)));
                        bus_errors++;
                    end
                    if (ar.id != (cur_vec.src == src_icache ? 4'd0 : 4'd1)) begin
                        report_value("ar.id", 128'(ar.id), 128'(cur_vec.src));
                        bus_errors++;
                    end
                    if (ar.len != 4'(cur_vec.beats - 3'd1)) begin
                        report_value("ar.len", 128'(ar.len), 128'(cur_vec.beats - 3'd1));
                        bus_errors++;
                    end
                    if (ar.size != 3'd2 || ar.burst != 2'd1) begin
                        report_value("ar.size/burst", 128'({ar.size, ar.burst}), 128'(5'b01001));
                        bus_errors++;
                    end
                end
            end else begin
                arready <= ready_draw();
            end
        end else begin
            if (rvalid && rready) begin
                beat_idx++;
                if (r.last) begin
                    burst_on = 1'b0;
                    if (beat_idx != int'(cur_vec.beats)) begin
                        report_value("beat count", 128'(beat_idx), 128'(cur_vec.beats));
                        bus_errors++;
                    end
                end
            end
            if (!burst_on)
                rvalid <= 1'b0;
            else if (rvalid && !rready)
                rvalid <= 1'b1;  // beat must hold
            else if (ready_draw()) begin
                rvalid <= 1'b1;
                r      <= '{id: cur_ar.id, data: model_word(cur_ar.addr + 32'(4 * beat_idx)),
                            resp: 2'b00, last: (beat_idx == int'(cur_ar.len))};
            end else
                rvalid <= 1'b0;
        end
    end

    task automatic check_ret();
        vec_t        e;
        line_t       exp_line;
        logic [31:0] base;
        if (ret_idx >= exp_log.size()) begin
            $display("[ERROR] %0t ns return seen with no request outstanding", $time);
            ret_errors++;
        end else begin
            e = exp_log[ret_idx];
            ret_idx <= ret_idx + 1;
            base = {e.addr[31:4], 4'h0};
            for (int k = 0; k < `LINE_WORDS; k++)
                exp_line[k*32 +: 32] = model_word(base + 32'(4 * k));
            if (icache_ret_valid && uc_ret_valid) begin
                $display("%0t ns both returns pulsed in the same cycle", $time);
                ret_errors++;
            end else if (e.src == src_icache && !icache_ret_valid) begin
                $display("%0t ns uncached return came where a line refill was due", $time);
                ret_errors++;
            end else if (e.src == src_uncached && !uc_ret_valid) begin
                $display("%0t ns line return came where an uncached word was due", $time);
                ret_errors++;
            end else if (e.src == src_icache && icache_ret_data != exp_line) begin
                report_value("icache_ret_data", icache_ret_data, exp_line);
                ret_errors++;
            end else if (e.src == src_uncached && uc_ret_data != model_word(e.addr)) begin
                report_value("uc_ret_data", 128'(uc_ret_data), 128'(model_word(e.addr)));
                ret_errors++;
            end
        end
    endtask

    // return checks and back-pressure on the requesters
    // queue level follows pushes and pops seen at the pins
    always @(posedge aclk) begin
        if (arst_n) begin
            if (q_cnt == `REQ_FIFO_DEPTH) begin
                full_seen <= 1'b1;
                if (icache_rdy || uc_rdy) begin
                    report_value("icache_rdy/uc_rdy", 128'({icache_rdy, uc_rdy}), 128'(0));
                    ret_errors++;
                end
            end
            q_cnt <= q_cnt + int'((icache_req && icache_rdy) || (uc_req && uc_rdy))
                     - int'(!eng_busy && q_cnt > 0);
            if (!eng_busy && q_cnt > 0)
                eng_busy <= 1'b1;       // head taken by an idle engine
            else if (rvalid && rready && r.last)
                eng_busy <= 1'b0;
            if (icache_ret_valid || uc_ret_valid)
                check_ret();
        end
    end

    task automatic issue_req(input vec_t v);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        @(posedge aclk);
        if (v.src == src_icache) begin
            icache_req  <= 1'b1;
            icache_addr <= v.addr;
        end else begin
            uc_req  <= 1'b1;
            uc_addr <= v.addr;
        end
        while (!taken && n < WAIT_MAX) begin
            @(posedge aclk);
            n++;
            taken = (v.src == src_icache) ? icache_rdy : uc_rdy;
        end
        icache_req <= 1'b0;
        uc_req     <= 1'b0;
        if (taken)
            exp_log.push_back(v);
        else begin
            $display("%0t ns request for %h was never accepted", $time, v.addr);
            tb_errors++;
        end
    endtask

    // a is the icache row, b the uncached one
    // icache keeps requesting until uncached wins, so the turn must pass
    task automatic issue_both(input vec_t a, input vec_t b);
        int   n;
        logic ic_done;
        logic uc_done;
        n = 0;
        ic_done = 1'b0;
        uc_done = 1'b0;
        @(posedge aclk);
        icache_req  <= 1'b1;
        icache_addr <= a.addr;
        uc_req      <= 1'b1;
        uc_addr     <= b.addr;
        while (!(ic_done && uc_done) && n < WAIT_MAX) begin
            @(posedge aclk);
            n++;
            if (!ic_done && !uc_done && icache_rdy && uc_rdy) begin
                $display("%0t ns both requesters granted in one cycle", $time);
                tb_errors++;
            end
            if (ic_done && !uc_done && icache_rdy) begin
                $display("%0t ns icache granted again while uncached waited", $time);
                tb_errors++;
            end
            if (!ic_done && icache_rdy) begin
                ic_done = 1'b1;
                exp_log.push_back(a);
                if (uc_done) begin
                    $display("%0t ns uncached granted ahead of icache", $time);
                    tb_errors++;
                end
            end
            if (!uc_done && uc_rdy) begin
                uc_done = 1'b1;
                uc_req <= 1'b0;
                exp_log.push_back(b);
            end
        end
        icache_req <= 1'b0;
        uc_req     <= 1'b0;
        if (!(ic_done && uc_done)) begin
            $display("%0t ns concurrent requests were not both accepted", $time);
            tb_errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (ret_idx < exp_log.size() && n < WAIT_MAX) begin
            @(posedge aclk);
            n++;
        end
        if (ret_idx < exp_log.size()) begin
            $display("%0t ns returns still missing after %0d cycles", $time, WAIT_MAX);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int now_err;
        now_err = tb_errors + bus_errors + ret_errors;
        tests_run++;
        if (now_err != err_mark) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, now_err - err_mark);
        end else
            $display("test %0d %s: ok", tests_run, name);
        err_mark = now_err;
    endtask

    initial begin
        arst_n      = 1'b0;
        icache_req  = 1'b0;
        icache_addr = '0;
        uc_req      = 1'b0;
        uc_addr     = '0;
        vec_tab[0]  = '{src_icache,   32'h1000_0124, 3'd4};
        vec_tab[1]  = '{src_uncached, 32'h2000_0a38, 3'd1};
        vec_tab[2]  = '{src_icache,   32'h1000_3f08, 3'd4};
        vec_tab[3]  = '{src_uncached, 32'h2000_5554, 3'd1};
        vec_tab[4]  = '{src_icache,   32'h0040_0000, 3'd4};
        vec_tab[5]  = '{src_uncached, 32'h1fc0_0010, 3'd1};
        vec_tab[6]  = '{src_icache,   32'h0040_00f4, 3'd4};
        vec_tab[7]  = '{src_icache,   32'h0040_8a2c, 3'd4};
        vec_tab[8]  = '{src_uncached, 32'h1faf_fffc, 3'd1};
        vec_tab[9]  = '{src_uncached, 32'h1faf_0004, 3'd1};
        vec_tab[10] = '{src_icache,   32'hbfc0_7ff0, 3'd4};
        vec_tab[11] = '{src_uncached, 32'hbfd0_c3a0, 3'd1};
        vec_tab[12] = '{src_icache,   32'h8000_ffff, 3'd4};
        vec_tab[13] = '{src_uncached, 32'h8000_1234, 3'd1};
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;
        @(posedge aclk);

        if ({arvalid, rready, icache_ret_valid, uc_ret_valid} !== 4'b0000) begin
            report_value("arvalid/rready/ret_valid",
                         128'({arvalid, rready, icache_ret_valid, uc_ret_valid}), 128'(0));
            tb_errors++;
        end
        finish_test("reset values");

        // first arbitration after reset
        issue_both(vec_tab[2], vec_tab[3]);
        wait_drain();
        finish_test("both requesters");

        issue_req(vec_tab[0]);
        wait_drain();
        finish_test("icache refill");

        issue_req(vec_tab[1]);
        wait_drain();
        finish_test("uncached read");

        // more rows than the queue holds, with bus stalls
        stall_on <= 1'b1;
        for (int i = 4; i < NUM_VEC; i++)
            issue_req(vec_tab[i]);
        wait_drain();
        stall_on <= 1'b0;
        if (!full_seen) begin
            $display("%0t ns the request queue never filled", $time);
            tb_errors++;
        end
        finish_test("stalled stream");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 tb_errors + bus_errors + ret_errors);
        if (tests_failed == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: axi_bridge.f
+incdir+common
common/axi_bridge_pkg.sv
logic/req_fifo.sv
axi_bridge/rd_arbiter.sv
axi_bridge/axi_rd_engine.sv
axi_bridge/axi_bridge_top.sv
bench/axi_bridge_chk.sv
bench/axi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f axi_bridge.f --top-module axi_bridge_tb \
    --Mdir obj_dir -o axi_bridge_sim || { echo "build error"; exit 1; }
./obj_dir/axi_bridge_sim > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
